/* hw/daq_pkg.sv */
package daq_pkg;

	localparam int ADDR_W   = 9;
	localparam int WORD_W   = 16;
	localparam int PERIOD_W = 32;
	localparam int FCNT_W   = 8;	// frame count field in status

	typedef logic [ADDR_W-1:0]   bus_addr_t;
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [PERIOD_W-1:0] period_t;

	localparam word_t VERSION_ID = 16'h1000;

	// register opcodes valued by their bus address
	typedef enum logic [ADDR_W-1:0] {
		op_version   = 9'h000,
		op_interval  = 9'h002,	// conversion interval in clocks
		op_enable    = 9'h004,
		op_fifo_clr  = 9'h006,
		op_status    = 9'h008,
		op_period_lo = 9'h00A,
		op_period_hi = 9'h00C,
		op_data      = 9'h00E,	// read pops one word
		op_miss      = 9'h010,
		op_none      = 9'h1FF
	} reg_op_e;

	typedef enum logic [2:0] {
		st_idle,
		st_convst,
		st_wait_busy_hi,
		st_wait_busy_lo,
		st_rd_low,
		st_rd_high,
		st_push
	} rdr_state_e;

endpackage

/* hw/bus_reg_decode.sv */
`timescale 1ns/1ps

module bus_reg_decode import daq_pkg::*; (
	input  logic              AD_CLK_40M,
	input  logic              reset_i,
	input  logic              mcu_cs_n_i,
	input  logic              mcu_we_n_i,
	input  logic              mcu_rd_n_i,
	input  bus_addr_t         mcu_addr_i,
	input  word_t             mcu_wdata_i,
	input  period_t           period_i,
	input  logic              period_valid_i,
	input  word_t             head_i,
	input  logic [FCNT_W-1:0] frame_cnt_i,
	input  word_t             miss_cnt_i,
	output word_t             mcu_rdata_o,
	output word_t             interval_o,
	output logic              enable_o,
	output logic              clr_o,
	output logic              pop_o
);

	reg_op_e op;
	logic    wr_en;
	logic    rd_en;
	word_t   status_word;

	assign wr_en = !mcu_cs_n_i && !mcu_we_n_i;	// one access per strobed cycle
	assign rd_en = !mcu_cs_n_i && !mcu_rd_n_i;

	//////////////////////////////
	// address decode

	always_comb begin
		case (mcu_addr_i)
			op_version,
			op_interval,
			op_enable,
			op_fifo_clr,
			op_status,
			op_period_lo,
			op_period_hi,
			op_data,
			op_miss: op = reg_op_e'(mcu_addr_i);
			default: op = op_none;
		endcase
	end

	// phase fault at bit 8 and frames in low byte
	assign status_word = {7'b0, !period_valid_i, frame_cnt_i};

	assign clr_o = wr_en && (op == op_fifo_clr) && mcu_wdata_i[0];
	assign pop_o = rd_en && (op == op_data);	// buffer advances at this edge

	//////////////////////////////
	// register writes

	always_ff @(posedge AD_CLK_40M) begin
		if (reset_i) begin
			interval_o <= '0;	// zero interval keeps scheduler idle
			enable_o   <= 1'b0;
		end else if (wr_en) begin
			case (op)
				op_interval: interval_o <= mcu_wdata_i;
				op_enable:   enable_o   <= mcu_wdata_i[0];
				default:     ;
			endcase
		end
	end

	//////////////////////////////
	// registered read mux

	always_ff @(posedge AD_CLK_40M) begin
		if (reset_i) begin
			mcu_rdata_o <= '0;
		end else if (rd_en) begin
			case (op)
				op_version:   mcu_rdata_o <= VERSION_ID;
				op_interval:  mcu_rdata_o <= interval_o;
				op_enable:    mcu_rdata_o <= {15'b0, enable_o};
				op_status:    mcu_rdata_o <= status_word;
				op_period_lo: mcu_rdata_o <= period_i[15:0];
				op_period_hi: mcu_rdata_o <= period_i[31:16];
				op_data:      mcu_rdata_o <= head_i;	// word before the pop
				op_miss:      mcu_rdata_o <= miss_cnt_i;
				default:      mcu_rdata_o <= '0;	// clr and unmapped
			endcase
		end
	end

endmodule

/* hw/phase_period_meter.sv */
`timescale 1ns/1ps

module phase_period_meter import daq_pkg::*; (
	input  logic    AD_CLK_40M,
	input  logic    reset_i,
	input  logic    phase_i,
	output period_t period_o,
	output logic    period_valid_o
);

	logic [1:0] phase_sync;	// two-flop synchronizer
	logic       phase_prev;
	logic       phase_rise;
	logic       seen_edge;	// first edge only starts the count
	period_t    cycle_cnt;

	assign phase_rise = phase_sync[1] && !phase_prev;

	always_ff @(posedge AD_CLK_40M) begin
		if (reset_i) begin
			phase_sync     <= 2'b00;
			phase_prev     <= 1'b0;
			seen_edge      <= 1'b0;
			cycle_cnt      <= '0;
			period_o       <= '0;
			period_valid_o <= 1'b0;
		end else begin
			phase_sync <= {phase_sync[0], phase_i};
			phase_prev <= phase_sync[1];
			if (phase_rise) begin
				cycle_cnt <= period_t'(1);	// edge cycle itself is count 0
				seen_edge <= 1'b1;
				if (seen_edge) begin
					period_o       <= cycle_cnt;
					period_valid_o <= 1'b1;
				end
			end else if (cycle_cnt != '1) begin
				cycle_cnt <= cycle_cnt + period_t'(1);	// saturates on a stopped shaft
			end
		end
	end

endmodule

/* hw/sample_scheduler.sv */
`timescale 1ns/1ps

module sample_scheduler import daq_pkg::*; (
	input  logic  AD_CLK_40M,
	input  logic  reset_i,
	input  logic  enable_i,
	input  logic  period_valid_i,
	input  word_t interval_i,
	output logic  start_o
);

	logic  allow;
	word_t tick_cnt;
	logic  tick_last;

	// no triggers without a valid key phase
	assign allow     = enable_i && period_valid_i && (interval_i != '0);
	assign tick_last = (tick_cnt == interval_i - 16'd1);

	always_ff @(posedge AD_CLK_40M) begin
		if (reset_i) begin
			tick_cnt <= '0;
			start_o  <= 1'b0;
		end else if (!allow) begin
			tick_cnt <= '0;	// reload so the first start is a full interval later
			start_o  <= 1'b0;
		end else if (tick_last) begin
			tick_cnt <= '0;
			start_o  <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 16'd1;
			start_o  <= 1'b0;
		end
	end

endmodule

/* hw/adc_conv_reader.sv */
`timescale 1ns/1ps

module adc_conv_reader import daq_pkg::*; #(
	parameter int NUM_CH     = 4,
	parameter int FRAMES     = 4,
	parameter int CONVST_CYC = 2,
	parameter int RD_CYC     = 2
) (
	input  logic  AD_CLK_40M,
	input  logic  reset_i,
	input  logic  start_i,
	input  logic  clr_i,
	input  logic  credit_i,
	input  logic  adc_busy_i,
	input  word_t adc_db_i,
	output logic  adc_convst_n_o,
	output logic  adc_cs_n_o,
	output logic  adc_rd_n_o,
	output logic  push_o,
	output word_t push_data_o,
	output word_t miss_cnt_o
);

	localparam int CRD_W   = $clog2(FRAMES + 1);
	localparam int CH_W    = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
	localparam int TMR_MAX = (CONVST_CYC > RD_CYC) ? CONVST_CYC : RD_CYC;
	localparam int TMR_W   = (TMR_MAX > 1) ? $clog2(TMR_MAX) : 1;

	rdr_state_e       state;
	logic [CRD_W-1:0] credits;	// free frame slots in the buffer
	logic [CRD_W-1:0] credits_nxt;
	logic [CH_W-1:0]  ch;
	logic [TMR_W-1:0] tmr;	// strobe width timer
	logic             rd_strobe_n;
	logic             accept;
	logic             rd_last;

	assign accept  = start_i && (state == st_idle) && (credits != '0);
	assign rd_last = (state == st_rd_low) && (tmr == TMR_W'(RD_CYC - 1));

	assign adc_cs_n_o = rd_strobe_n;	// cs and rd move together
	assign adc_rd_n_o = rd_strobe_n;

	//////////////////////////////
	// credits and misses

	always_comb begin
		credits_nxt = credits;
		if (accept)
			credits_nxt = credits_nxt - CRD_W'(1);	// spent at the start
		if (credit_i)
			credits_nxt = credits_nxt + CRD_W'(1);
	end

	always_ff @(posedge AD_CLK_40M) begin
		if (reset_i || clr_i)
			credits <= CRD_W'(FRAMES);
		else
			credits <= credits_nxt;
	end

	always_ff @(posedge AD_CLK_40M) begin
		if (reset_i)
			miss_cnt_o <= '0;
		else if (start_i && !accept && (miss_cnt_o != '1))
			miss_cnt_o <= miss_cnt_o + 16'd1;	// busy or no credit
	end

	//////////////////////////////
	// conversion and readout FSM

	always_ff @(posedge AD_CLK_40M) begin
		if (reset_i || clr_i) begin
			state          <= st_idle;
			adc_convst_n_o <= 1'b1;
			rd_strobe_n    <= 1'b1;
			push_o         <= 1'b0;
			ch             <= '0;
			tmr            <= '0;
		end else begin
			push_o <= 1'b0;
			case (state)
				st_idle: begin
					if (accept) begin
						adc_convst_n_o <= 1'b0;
						tmr            <= '0;
						state          <= st_convst;
					end
				end
				st_convst: begin
					if (tmr == TMR_W'(CONVST_CYC - 1)) begin
						adc_convst_n_o <= 1'b1;
						state          <= st_wait_busy_hi;
					end else begin
						tmr <= tmr + TMR_W'(1);
					end
				end
				st_wait_busy_hi: if (adc_busy_i) state <= st_wait_busy_lo;
				st_wait_busy_lo: begin
					if (!adc_busy_i) begin	// conversion done
						rd_strobe_n <= 1'b0;
						tmr         <= '0;
						ch          <= '0;
						state       <= st_rd_low;
					end
				end
				st_rd_low: begin
					if (rd_last) begin
						rd_strobe_n <= 1'b1;
						push_o      <= 1'b1;
						state       <= (ch == CH_W'(NUM_CH - 1)) ? st_push : st_rd_high;
					end else begin
						tmr <= tmr + TMR_W'(1);
					end
				end
				st_rd_high: begin	// one high cycle between words
					rd_strobe_n <= 1'b0;
					tmr         <= '0;
					ch          <= ch + CH_W'(1);
					state       <= st_rd_low;
				end
				st_push: state <= st_idle;	// last word of the frame
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge AD_CLK_40M) begin
		if (rd_last)
			push_data_o <= adc_db_i;
	end

endmodule

/* hw/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer import daq_pkg::*; #(
	parameter int NUM_CH = 4,
	parameter int FRAMES = 4
) (
	input  logic              AD_CLK_40M,
	input  logic              reset_i,
	input  logic              clr_i,
	input  logic              push_i,
	input  word_t             push_data_i,
	input  logic              pop_i,
	output word_t             head_o,
	output logic [FCNT_W-1:0] frame_cnt_o,
	output logic              credit_o
);

	localparam int DEPTH = NUM_CH * FRAMES;
	localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CH_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

	word_t            mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CNT_W-1:0] word_cnt;
	logic [CH_W-1:0]  wr_ch;	// word position in the frame being pushed
	logic [CH_W-1:0]  rd_ch;
	logic             do_push;
	logic             do_pop;
	logic             frame_in;
	logic             frame_out;

	assign do_push   = push_i && (word_cnt != CNT_W'(DEPTH));
	assign do_pop    = pop_i && (word_cnt != '0);	// empty pop ignored
	assign frame_in  = do_push && (wr_ch == CH_W'(NUM_CH - 1));
	assign frame_out = do_pop && (rd_ch == CH_W'(NUM_CH - 1));
	assign head_o    = (word_cnt != '0) ? mem[rd_ptr] : '0;

	always_ff @(posedge AD_CLK_40M) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	//////////////////////////////
	// pointers and counts

	always_ff @(posedge AD_CLK_40M) begin
		if (reset_i || clr_i) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			word_cnt    <= '0;
			wr_ch       <= '0;
			rd_ch       <= '0;
			frame_cnt_o <= '0;
			credit_o    <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
				wr_ch  <= (wr_ch == CH_W'(NUM_CH - 1)) ? '0 : wr_ch + CH_W'(1);
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
				rd_ch  <= (rd_ch == CH_W'(NUM_CH - 1)) ? '0 : rd_ch + CH_W'(1);
			end
			case ({do_push, do_pop})
				2'b10:   word_cnt <= word_cnt + CNT_W'(1);
				2'b01:   word_cnt <= word_cnt - CNT_W'(1);
				default: ;
			endcase
			case ({frame_in, frame_out})
				2'b10:   frame_cnt_o <= frame_cnt_o + 8'd1;
				2'b01:   frame_cnt_o <= frame_cnt_o - 8'd1;
				default: ;
			endcase
			credit_o <= frame_out;	// freed slot goes back as a credit
		end
	end

endmodule

/* hw/daq_top.sv */
`timescale 1ns/1ps

module daq_top import daq_pkg::*; #(
	parameter int NUM_CH     = 4,
	parameter int FRAMES     = 4,
	parameter int CONVST_CYC = 2,
	parameter int RD_CYC     = 2
) (
	input  logic      AD_CLK_40M,
	input  logic      reset_i,
	input  logic      mcu_cs_n_i,
	input  logic      mcu_we_n_i,
	input  logic      mcu_rd_n_i,
	input  bus_addr_t mcu_addr_i,
	input  word_t     mcu_wdata_i,
	output word_t     mcu_rdata_o,
	input  logic      phase_i,
	input  word_t     adc_db_i,
	input  logic      adc_busy_i,
	output logic      adc_convst_n_o,
	output logic      adc_cs_n_o,
	output logic      adc_rd_n_o
);

	word_t             interval;
	logic              enable;
	logic              clr;
	logic              pop;
	period_t           period;
	logic              period_valid;
	word_t             head;
	logic [FCNT_W-1:0] frame_cnt;
	word_t             miss_cnt;
	logic              start;
	logic              push;
	word_t             push_data;
	logic              credit;

	//////////////////////////////
	// register decode

	bus_reg_decode u_decode (
		.AD_CLK_40M(AD_CLK_40M), .reset_i(reset_i),
		.mcu_cs_n_i(mcu_cs_n_i), .mcu_we_n_i(mcu_we_n_i), .mcu_rd_n_i(mcu_rd_n_i),
		.mcu_addr_i(mcu_addr_i), .mcu_wdata_i(mcu_wdata_i),
		.period_i(period), .period_valid_i(period_valid), .head_i(head),
		.frame_cnt_i(frame_cnt), .miss_cnt_i(miss_cnt), .mcu_rdata_o(mcu_rdata_o),
		.interval_o(interval), .enable_o(enable), .clr_o(clr), .pop_o(pop)
	);

	//////////////////////////////
	// trigger and conversion

	phase_period_meter u_meter (
		.AD_CLK_40M(AD_CLK_40M), .reset_i(reset_i), .phase_i(phase_i),
		.period_o(period), .period_valid_o(period_valid)
	);

	sample_scheduler u_sched (
		.AD_CLK_40M(AD_CLK_40M), .reset_i(reset_i), .enable_i(enable),
		.period_valid_i(period_valid), .interval_i(interval), .start_o(start)
	);

	adc_conv_reader #(
		.NUM_CH(NUM_CH), .FRAMES(FRAMES), .CONVST_CYC(CONVST_CYC), .RD_CYC(RD_CYC)
	) u_reader (
		.AD_CLK_40M(AD_CLK_40M), .reset_i(reset_i), .start_i(start), .clr_i(clr),
		.credit_i(credit), .adc_busy_i(adc_busy_i), .adc_db_i(adc_db_i),
		.adc_convst_n_o(adc_convst_n_o), .adc_cs_n_o(adc_cs_n_o), .adc_rd_n_o(adc_rd_n_o),
		.push_o(push), .push_data_o(push_data), .miss_cnt_o(miss_cnt)
	);

	frame_buffer #(.NUM_CH(NUM_CH), .FRAMES(FRAMES)) u_buffer (
		.AD_CLK_40M(AD_CLK_40M), .reset_i(reset_i), .clr_i(clr), .push_i(push),
		.push_data_i(push_data), .pop_i(pop), .head_o(head),
		.frame_cnt_o(frame_cnt), .credit_o(credit)
	);

endmodule

/* sim/adc_model.sv */
`timescale 1ns/1ps

module adc_model import daq_pkg::*; (
	input  logic  AD_CLK_40M,
	input  logic  reset_i,
	input  logic  convst_n_i,
	input  logic  cs_n_i,
	input  logic  rd_n_i,
	output logic  busy_o,
	output word_t db_o
);

	logic        convst_prev;
	logic        strobe;
	logic        strobe_prev;
	logic [11:0] conv_num;	// conversion being read out
	logic [11:0] conv_next;
	logic [3:0]  ch;
	int          pend;	// cycles left before busy rises
	int          busy_left;

	initial begin
		convst_prev = 1'b1;
		strobe      = 1'b0;
		strobe_prev = 1'b0;
		conv_num    = '0;
		conv_next   = '0;
		ch          = '0;
		pend        = 0;
		busy_left   = 0;
		busy_o      = 1'b0;
		db_o        = '0;
	end

	always @(posedge AD_CLK_40M) begin
		#1;
		strobe = !cs_n_i && !rd_n_i;
		if (reset_i) begin
			conv_next = '0;
			conv_num  = '0;
			ch        = '0;
			pend      = 0;
			busy_o    = 1'b0;
		end else begin
			if (convst_prev && !convst_n_i) begin
				conv_num  = conv_next;	// new conversion
				conv_next = conv_next + 12'd1;
				ch        = '0;
				pend      = 2;
			end else if (pend > 0) begin
				pend = pend - 1;
				if (pend == 0) begin
					busy_o    = 1'b1;
					busy_left = 3 + int'($urandom % 8);	// 3 to 10 cycles
				end
			end else if (busy_o) begin
				busy_left = busy_left - 1;
				if (busy_left == 0)
					busy_o = 1'b0;
			end
			if (strobe_prev && !strobe)
				ch = ch + 4'd1;	// next channel after each read strobe
		end
		convst_prev = convst_n_i;
		strobe_prev = strobe;
		db_o        = {conv_num, ch};
	end

endmodule

/* sim/tb_daq.sv */
`timescale 1ns/1ps

module tb_daq import daq_pkg::*; ();

	localparam int NUM_CH    = 4;
	localparam int FRAMES    = 4;
	localparam int PHASE_CYC = 300;	// key-phase period in clocks
	localparam int MAX_CYC   = 20000;	// several times the expected run

	logic        AD_CLK_40M = 1'b0;
	logic        reset_i;
	logic        mcu_cs_n;
	logic        mcu_we_n;
	logic        mcu_rd_n;
	bus_addr_t   mcu_addr;
	word_t       mcu_wdata;
	word_t       mcu_rdata;
	logic        phase = 1'b0;
	logic        phase_run = 1'b0;
	int          phase_cnt = PHASE_CYC - 1;	// first step wraps to 0 and rises
	logic        adc_busy;
	word_t       adc_db;
	logic        adc_convst_n;
	logic        adc_cs_n;
	logic        adc_rd_n;
	int          cycles = 0;

	word_t       expected[$];	// words of every accepted conversion
	int          exp_rd = 0;	// next expected word to pop
	logic [11:0] conv_idx;
	int          rd_pulses;
	logic        conv_seen;
	logic        busy_done;	// busy fell since the last CONVST
	logic        convst_q;
	logic        rd_q;
	logic        busy_q;

	daq_top #(
		.NUM_CH(NUM_CH), .FRAMES(FRAMES), .CONVST_CYC(2), .RD_CYC(2)
	) dut0 (
		.AD_CLK_40M(AD_CLK_40M), .reset_i(reset_i),
		.mcu_cs_n_i(mcu_cs_n), .mcu_we_n_i(mcu_we_n), .mcu_rd_n_i(mcu_rd_n),
		.mcu_addr_i(mcu_addr), .mcu_wdata_i(mcu_wdata), .mcu_rdata_o(mcu_rdata),
		.phase_i(phase), .adc_db_i(adc_db), .adc_busy_i(adc_busy),
		.adc_convst_n_o(adc_convst_n), .adc_cs_n_o(adc_cs_n), .adc_rd_n_o(adc_rd_n)
	);

	adc_model adc0 (
		.AD_CLK_40M(AD_CLK_40M), .reset_i(reset_i), .convst_n_i(adc_convst_n),
		.cs_n_i(adc_cs_n), .rd_n_i(adc_rd_n), .busy_o(adc_busy), .db_o(adc_db)
	);

	always #50 AD_CLK_40M = ~AD_CLK_40M;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	always @(posedge AD_CLK_40M) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYC)
			stop_on_error($sformatf("timeout, tests still running after %0d cycles", MAX_CYC));
	end

	always @(posedge AD_CLK_40M) begin
		#1;
		if (phase_run) begin
			phase_cnt = (phase_cnt == PHASE_CYC - 1) ? 0 : phase_cnt + 1;
			phase     = (phase_cnt < 5);	// short pulse once per revolution
		end
	end

	function automatic void queue_frame(input logic [11:0] conv);
		int c;
		for (c = 0; c < NUM_CH; c++)
			expected.push_back({conv, 4'(c)});
	endfunction

	//////////////////////////////
	// ADC pin monitor

	always @(posedge AD_CLK_40M) begin
		if (reset_i) begin
			convst_q  <= 1'b1;
			rd_q      <= 1'b1;
			busy_q    <= 1'b0;
			busy_done <= 1'b0;
			conv_seen <= 1'b0;
			conv_idx  <= '0;
			rd_pulses <= 0;
		end else begin
			convst_q <= adc_convst_n;
			rd_q     <= adc_rd_n;
			busy_q   <= adc_busy;
			if (convst_q && !adc_convst_n) begin	// conversion accepted
				if (conv_seen)
					assert (rd_pulses == NUM_CH)
						else stop_on_error($sformatf("mismatch at %0t: rd pulses expected %0d got %0d",
							$time, NUM_CH, rd_pulses));
				queue_frame(conv_idx);
				conv_idx  <= conv_idx + 12'd1;
				conv_seen <= 1'b1;
				busy_done <= 1'b0;
				rd_pulses <= 0;
			end
			if (busy_q && !adc_busy)
				busy_done <= 1'b1;
			if (rd_q && !adc_rd_n) begin
				assert (rd_pulses < NUM_CH)
					else stop_on_error("more RD pulses than channels in one conversion");
				rd_pulses <= rd_pulses + 1;
			end
		end
	end

	convst_rd_apart: assert property (@(posedge AD_CLK_40M) disable iff (reset_i)
		adc_convst_n || adc_rd_n)
		else stop_on_error("CONVST and RD were low in the same cycle");

	rd_after_busy: assert property (@(posedge AD_CLK_40M) disable iff (reset_i)
		adc_rd_n || (busy_done && !adc_busy))
		else stop_on_error("RD went low before BUSY had fallen");

	cs_with_rd: assert property (@(posedge AD_CLK_40M) disable iff (reset_i)
		adc_cs_n == adc_rd_n)
		else stop_on_error("CS and RD strobes did not move together");

	//////////////////////////////
	// MCU bus access

	task automatic bus_write(input bus_addr_t addr, input word_t data);
		@(posedge AD_CLK_40M);
		#1;
		mcu_cs_n  = 1'b0;
		mcu_we_n  = 1'b0;
		mcu_addr  = addr;
		mcu_wdata = data;
		@(posedge AD_CLK_40M);	// register takes data here
		#1;
		mcu_cs_n = 1'b1;
		mcu_we_n = 1'b1;
	endtask

	task automatic bus_read(input bus_addr_t addr, output word_t data);
		@(posedge AD_CLK_40M);
		#1;
		mcu_cs_n = 1'b0;
		mcu_rd_n = 1'b0;
		mcu_addr = addr;
		@(posedge AD_CLK_40M);
		#1;
		mcu_cs_n = 1'b1;
		mcu_rd_n = 1'b1;
		data     = mcu_rdata;	// registered at the strobe edge
	endtask

	task automatic read_expect(input bus_addr_t addr, input word_t exp, input string name);
		word_t got;
		bus_read(addr, got);
		assert (got == exp)
			else stop_on_error($sformatf("mismatch at %0t: %s expected %h got %h",
				$time, name, exp, got));
	endtask

	task automatic wait_frames(input int want);
		word_t st;
		do begin
			bus_read(op_status, st);
			assert (int'(st[7:0]) <= FRAMES)
				else stop_on_error($sformatf("mismatch at %0t: frame count expected <= %0d got %0d",
					$time, FRAMES, st[7:0]));
		end while (int'(st[7:0]) < want);
	endtask

	task automatic pop_frame();
		word_t got;
		int    i;
		for (i = 0; i < NUM_CH; i++) begin
			assert (exp_rd < expected.size())
				else stop_on_error("data word popped with no accepted conversion behind it");
			bus_read(op_data, got);
			assert (got == expected[exp_rd])
				else stop_on_error($sformatf("mismatch at %0t: data expected %h got %h",
					$time, expected[exp_rd], got));
			exp_rd++;
		end
	endtask

	//////////////////////////////
	// test sequence

	initial begin
		word_t st;
		word_t lo;
		word_t hi;
		word_t miss0;
		word_t miss1;
		void'($urandom(32'h50b));
		reset_i   = 1'b1;
		mcu_cs_n  = 1'b1;
		mcu_we_n  = 1'b1;
		mcu_rd_n  = 1'b1;
		mcu_addr  = '0;
		mcu_wdata = '0;
		repeat (10) @(posedge AD_CLK_40M);
		#1;
		reset_i = 1'b0;

		read_expect(op_version, VERSION_ID, "version");
		bus_write(op_interval, 16'd200);
		read_expect(op_interval, 16'd200, "interval");
		read_expect(9'h1F0, 16'h0000, "unmapped read");
		read_expect(op_fifo_clr, 16'h0000, "fifo clear read");

		// key phase first absent and then measured
		bus_read(op_status, st);
		assert (st[8] == 1'b1)
			else stop_on_error($sformatf("mismatch at %0t: phase fault expected 1 got %b", $time, st[8]));
		phase_run = 1'b1;
		do
			bus_read(op_status, st);
		while (st[8]);
		bus_read(op_period_lo, lo);
		bus_read(op_period_hi, hi);
		assert ({hi, lo} == 32'(PHASE_CYC))
			else stop_on_error($sformatf("mismatch at %0t: period expected %0d got %0d",
				$time, PHASE_CYC, {hi, lo}));

		// data order at a slow rate
		bus_write(op_enable, 16'd1);
		read_expect(op_enable, 16'd1, "enable");
		repeat (2) begin
			wait_frames(1);
			pop_frame();
		end

		// back-pressure with a short interval
		bus_write(op_enable, 16'd0);	// reload the scheduler before the new interval
		bus_write(op_interval, 16'd40);
		bus_write(op_enable, 16'd1);
		wait_frames(FRAMES);
		bus_read(op_miss, miss0);
		do
			bus_read(op_miss, miss1);
		while (miss1 == miss0);
		read_expect(op_status, word_t'(FRAMES), "status when full");
		pop_frame();
		read_expect(op_status, word_t'(FRAMES - 1), "status after one frame popped");
		wait_frames(FRAMES);
		bus_write(op_enable, 16'd0);
		repeat (FRAMES) pop_frame();
		assert (exp_rd == expected.size())
			else stop_on_error("accepted conversions left over after the buffer was emptied");

		// clear a full buffer
		bus_write(op_enable, 16'd1);
		wait_frames(FRAMES);
		bus_write(op_enable, 16'd0);
		bus_write(op_fifo_clr, 16'd1);
		exp_rd = expected.size();	// cleared frames are gone
		read_expect(op_status, 16'h0000, "status after clear");
		read_expect(op_data, 16'h0000, "data after clear");
		bus_write(op_enable, 16'd1);
		wait_frames(FRAMES);
		bus_write(op_enable, 16'd0);
		pop_frame();

		assert (rd_pulses == NUM_CH)
			else stop_on_error($sformatf("mismatch at %0t: rd pulses expected %0d got %0d",
				$time, NUM_CH, rd_pulses));
		$display("TEST OK");
		$finish;
	end

endmodule

/* tb.f */
hw/daq_pkg.sv
hw/bus_reg_decode.sv
hw/phase_period_meter.sv
hw/sample_scheduler.sv
hw/adc_conv_reader.sv
hw/frame_buffer.sv
hw/daq_top.sv
sim/adc_model.sv
sim/tb_daq.sv

/* Makefile */
SRC := tb.f $(wildcard hw/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_daq: $(SRC)
	verilator --binary --timing --assert --top-module tb_daq -f tb.f

run: obj_dir/Vtb_daq
	@out="$$(./obj_dir/Vtb_daq)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
